// File: Bender.yml
package:
  name: sd_datin_readout

sources:
  # Synthesizable design, package first
  - target: rtl
    files:
      - hdl/sd_datin_pkg.sv
      - hdl/cmd6_mode_capture.sv
      - hdl/datin_fifo.sv
      - hdl/host_regs.sv
      - hdl/sd_datin_readout.sv

  # Testbench, compiled after the design
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/sd_datin_readout_asserts.sv
      - testbench/sd_datin_readout_tb.sv

// File: hdl/cmd6_mode_capture.sv
`timescale 1ns/1ps
`default_nettype none

module cmd6_mode_capture
    import sd_datin_pkg::*;
(
    input  logic              sd_datInWrite_clk,
    input  logic              spi_rst_,
    input  logic              datin_rst,   // Block restart that keeps status
    input  logic              accept,
    input  logic [WORD_W-1:0] data,
    output mode_status_t      status
);

    logic [BLKIDX_W-1:0] word_idx;
    logic                last_word;
    logic                mode_word;

    assign last_word = (word_idx == BLKIDX_W'(BLOCK_WORDS - 1));
    assign mode_word = (word_idx == BLKIDX_W'(MODE_WORD_IDX));

    // ====================
    // Word index in block
    // ====================
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            word_idx <= '0;
        end else if (datin_rst) begin
            word_idx <= '0;
        end else if (accept) begin
            if (last_word) begin
                word_idx <= '0;
            end else begin
                word_idx <= word_idx + 1'b1;
            end
        end
    end

    // Access mode and completed blocks
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            status <= '0;
        end else if (accept && !datin_rst) begin
            if (mode_word) begin
                status.access_mode <= data[MODE_LSB +: MODE_W];
            end
            if (last_word) begin
                status.block_count <= status.block_count + 1'b1;  // Free-running wrap
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/datin_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module datin_fifo
    import sd_datin_pkg::*;
(
    input  logic               sd_datInWrite_clk,
    input  logic               spi_rst_,
    input  logic               datin_rst,
    input  datin_word_t        datin,
    output logic               ready,
    output logic               accept,
    input  logic               pop,      // Only issued when not empty
    output logic [WORD_W-1:0]  head,
    output logic [LEVEL_W-1:0] level
);

    logic [WORD_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic              full;

    assign full = (level == LEVEL_W'(FIFO_DEPTH));

    // No handshake while the block restarts, so no word gets dropped
    assign ready  = !full && !datin_rst;
    assign accept = datin.trigger && ready;
    assign head   = mem[rd_ptr];

    // ====================
    // Storage
    // ====================
    always_ff @(posedge sd_datInWrite_clk) begin
        if (accept) begin
            mem[wr_ptr] <= datin.data;
        end
    end

    // ====================
    // Pointers and level
    // ====================
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else if (datin_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (accept) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at FIFO_DEPTH
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({accept, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;  // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/host_regs.sv
`timescale 1ns/1ps
`default_nettype none

module host_regs
    import sd_datin_pkg::*;
(
    input  logic               sd_datInWrite_clk,
    input  logic               spi_rst_,
    input  apb_req_t           apb_req,
    output apb_rsp_t           apb_rsp,
    input  mode_status_t       status,
    input  logic [WORD_W-1:0]  head,
    input  logic [LEVEL_W-1:0] level,
    output logic               pop,
    output logic [3:0]         led
);

    logic [APB_DATA_W-1:0] echo_q;
    logic [APB_DATA_W-1:0] status_word;
    logic [APB_DATA_W-1:0] rdata;
    reg_addr_e             addr;
    logic                  access;
    logic                  wr_en;
    logic                  rd_en;
    logic                  addr_ok;
    logic                  fifo_empty;
    logic                  data_rd;

    // ====================
    // Access decode
    // ====================
    assign addr   = reg_addr_e'(apb_req.addr);
    assign access = apb_req.sel && apb_req.enable;  // Access phase only
    assign wr_en  = access && apb_req.write;
    assign rd_en  = access && !apb_req.write;

    always_comb begin
        case (addr)
            REG_ECHO, REG_LED, REG_STATUS, REG_DATA: addr_ok = 1'b1;
            default:                                 addr_ok = 1'b0;
        endcase
    end

    assign fifo_empty = (level == '0);
    assign data_rd    = rd_en && (addr == REG_DATA);
    assign pop        = data_rd && !fifo_empty;

    // Mode in the low nibble, block count and level above it
    always_comb begin
        status_word        = '0;
        status_word[3:0]   = status.access_mode;
        status_word[15:8]  = status.block_count;
        status_word[22:16] = level;
    end

    // ====================
    // Read data
    // ====================
    always_comb begin
        case (addr)
            REG_ECHO:   rdata = echo_q;
            REG_LED:    rdata = APB_DATA_W'(led);
            REG_STATUS: rdata = status_word;
            REG_DATA:   rdata = APB_DATA_W'(head);
            default:    rdata = '0;
        endcase
    end

    assign apb_rsp.rdata  = rdata;
    assign apb_rsp.ready  = 1'b1;  // Zero wait states
    assign apb_rsp.slverr = access && (!addr_ok || (data_rd && fifo_empty));

    // ====================
    // Writable registers
    // ====================
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            echo_q <= '0;
            led    <= '0;
        end else if (wr_en) begin
            case (addr)
                REG_ECHO: echo_q <= apb_req.wdata;
                REG_LED:  led    <= apb_req.wdata[3:0];
                default:  ;  // Status and data are read only
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/sd_datin_pkg.sv
`default_nettype none

package sd_datin_pkg;

    // ====================
    // SD data-in stream
    // ====================
    localparam int WORD_W        = 16;
    localparam int BLOCK_WORDS   = 32;   // 512-bit CMD6 status block
    localparam int BLKIDX_W      = $clog2(BLOCK_WORDS);
    localparam int MODE_WORD_IDX = 8;    // Word that carries the access mode
    localparam int MODE_LSB      = 8;
    localparam int MODE_W        = 4;
    localparam int BLKCNT_W      = 8;    // Wraps

    // ====================
    // Readout FIFO
    // ====================
    localparam int FIFO_DEPTH = 64;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);
    localparam int LEVEL_W    = PTR_W + 1;  // Holds 0 to FIFO_DEPTH

    // ====================
    // Host APB side
    // ====================
    localparam int APB_ADDR_W = 4;
    localparam int APB_DATA_W = 32;

    typedef enum logic [APB_ADDR_W-1:0] {
        REG_ECHO   = 4'd0,
        REG_LED    = 4'd4,
        REG_STATUS = 4'd8,
        REG_DATA   = 4'd12
    } reg_addr_e;

    typedef struct packed {
        logic              trigger;
        logic [WORD_W-1:0] data;
    } datin_word_t;

    typedef struct packed {
        logic [MODE_W-1:0]   access_mode;
        logic [BLKCNT_W-1:0] block_count;
    } mode_status_t;

    typedef struct packed {
        logic                  sel;
        logic                  enable;
        logic                  write;
        logic [APB_ADDR_W-1:0] addr;
        logic [APB_DATA_W-1:0] wdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DATA_W-1:0] rdata;
        logic                  ready;
        logic                  slverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

// File: hdl/sd_datin_readout.sv
`timescale 1ns/1ps
`default_nettype none

module sd_datin_readout
    import sd_datin_pkg::*;
(
    input  logic        sd_datInWrite_clk,
    input  logic        spi_rst_,
    input  logic        datin_rst,
    input  datin_word_t datin,
    output logic        datin_ready,
    input  apb_req_t    apb_req,
    output apb_rsp_t    apb_rsp,
    output logic [3:0]  led
);

    logic               accept;
    logic               pop;
    logic [WORD_W-1:0]  head;
    logic [LEVEL_W-1:0] level;
    mode_status_t       mode_status;

    // ====================
    // SD side
    // ====================
    datin_fifo u_datin_fifo (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .datin_rst         (datin_rst),
        .datin             (datin),
        .ready             (datin_ready),
        .accept            (accept),
        .pop               (pop),
        .head              (head),
        .level             (level)
    );

    cmd6_mode_capture u_cmd6_mode_capture (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .datin_rst         (datin_rst),
        .accept            (accept),   // Same strobe that writes the FIFO
        .data              (datin.data),
        .status            (mode_status)
    );

    // Host side
    host_regs u_host_regs (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .apb_req           (apb_req),
        .apb_rsp           (apb_rsp),
        .status            (mode_status),
        .head              (head),
        .level             (level),
        .pop               (pop),
        .led               (led)
    );

endmodule

`default_nettype wire

// File: sd_datin_readout.f
hdl/sd_datin_pkg.sv
hdl/cmd6_mode_capture.sv
hdl/datin_fifo.sv
hdl/host_regs.sv
hdl/sd_datin_readout.sv
testbench/tb_clock_gen.sv
testbench/sd_datin_readout_asserts.sv
testbench/sd_datin_readout_tb.sv

// File: testbench/sd_datin_readout_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module sd_datin_readout_asserts
    import sd_datin_pkg::*;
(
    input logic        sd_datInWrite_clk,
    input logic        spi_rst_,
    input datin_word_t datin,
    input logic        datin_ready,
    input apb_req_t    apb_req,
    input apb_rsp_t    apb_rsp
);

    int assert_errors = 0;  // Failed assertions so far

    // Writer keeps a refused word in place
    held_word_stable: assert property (@(posedge sd_datInWrite_clk) disable iff (!spi_rst_)
        datin.trigger && !datin_ready |=> datin.trigger && $stable(datin.data))
        else begin
            assert_errors++;
            $error("stream word dropped or changed before acceptance");
        end

    // Setup cycle is always followed by the access cycle
    setup_then_access: assert property (@(posedge sd_datInWrite_clk) disable iff (!spi_rst_)
        apb_req.sel && !apb_req.enable |=> apb_req.sel && apb_req.enable)
        else begin
            assert_errors++;
            $error("APB setup cycle not followed by access cycle");
        end

    access_ready: assert property (@(posedge sd_datInWrite_clk) disable iff (!spi_rst_)
        apb_req.sel && apb_req.enable |-> apb_rsp.ready)
        else begin
            assert_errors++;
            $error("APB access cycle without ready");
        end

endmodule

bind sd_datin_readout sd_datin_readout_asserts u_asserts (
    .sd_datInWrite_clk (sd_datInWrite_clk),
    .spi_rst_          (spi_rst_),
    .datin             (datin),
    .datin_ready       (datin_ready),
    .apb_req           (apb_req),
    .apb_rsp           (apb_rsp)
);

`default_nettype wire

// File: testbench/sd_datin_readout_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sd_datin_readout_tb
    import sd_datin_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 200;

    logic        sd_datInWrite_clk;
    logic        spi_rst_;
    logic        datin_rst;
    datin_word_t datin;
    logic        datin_ready;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic [3:0]  led;

    logic [31:0]         lcg_state = 32'h4158;
    logic [WORD_W-1:0]   sent_words[$];  // Model of the FIFO contents
    logic [MODE_W-1:0]   exp_mode = '0;
    logic [BLKCNT_W-1:0] exp_blocks = '0;
    string               test_name;
    int                  error_count = 0;
    int                  test_count = 0;
    int                  test_start_errors;

    tb_clock_gen u_clock_gen (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_)
    );

    sd_datin_readout dut (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .datin_rst         (datin_rst),
        .datin             (datin),
        .datin_ready       (datin_ready),
        .apb_req           (apb_req),
        .apb_rsp           (apb_rsp),
        .led               (led)
    );

    // ====================
    // Helpers
    // ====================
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s %s: expected %h, actual %h",
                     test_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic step_past_edge();
        @(posedge sd_datInWrite_clk);
        #1;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_start_errors = error_count;
        test_count++;
    endtask

    task automatic end_test();
        $display("%s finished with %0d errors", test_name, error_count - test_start_errors);
    endtask

    // Setup, access, then idle; response sampled mid access cycle
    task automatic apb_access(input logic is_write, input logic [APB_ADDR_W-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic slverr);
        int waited;
        waited = 0;
        step_past_edge();
        apb_req = '{sel: 1'b1, enable: 1'b0, write: is_write, addr: addr, wdata: wdata};
        step_past_edge();
        apb_req.enable = 1'b1;
        @(negedge sd_datInWrite_clk);
        while (!apb_rsp.ready && waited < TIMEOUT_CYCLES) begin
            @(negedge sd_datInWrite_clk);
            waited++;
        end
        if (!apb_rsp.ready) begin
            $display("%s: APB access to address %h never got ready", test_name, addr);
            error_count++;
        end
        rdata  = apb_rsp.rdata;
        slverr = apb_rsp.slverr;
        step_past_edge();
        apb_req = '0;
    endtask

    task automatic read_reg(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] rdata,
                            output logic slverr);
        apb_access(1'b0, addr, '0, rdata, slverr);
    endtask

    task automatic write_reg(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] wdata);
        logic [31:0] rdata;
        logic        slverr;
        apb_access(1'b1, addr, wdata, rdata, slverr);
        check_value("write slverr", 0, slverr);
    endtask

    // Trigger already high; drops it after the accepting edge
    task automatic wait_accept();
        int waited;
        waited = 0;
        @(negedge sd_datInWrite_clk);
        while (!datin_ready && waited < TIMEOUT_CYCLES) begin
            @(negedge sd_datInWrite_clk);
            waited++;
        end
        if (!datin_ready) begin
            $display("%s: stream word was never accepted", test_name);
            error_count++;
        end
        step_past_edge();
        datin.trigger = 1'b0;
    endtask

    task automatic send_words(input int count, input bit keep);
        logic [WORD_W-1:0] word;
        for (int i = 0; i < count; i++) begin
            word = WORD_W'(lcg_next() >> 16);
            step_past_edge();
            datin = '{trigger: 1'b1, data: word};
            wait_accept();
            if (keep) sent_words.push_back(word);
        end
    endtask

    task automatic check_status(input int level);
        logic [31:0] rdata;
        logic        slverr;
        read_reg(REG_STATUS, rdata, slverr);
        check_value("status slverr", 0, slverr);
        check_value("access mode", exp_mode, rdata[3:0]);
        check_value("block count", exp_blocks, rdata[15:8]);
        check_value("fifo level", level, rdata[22:16]);
    endtask

    task automatic drain_and_compare();
        logic [31:0] rdata;
        logic        slverr;
        while (sent_words.size() > 0) begin
            read_reg(REG_DATA, rdata, slverr);
            check_value("data word", sent_words.pop_front(), rdata);
            check_value("data slverr", 0, slverr);
        end
    endtask

    // ====================
    // Tests
    // ====================
    task automatic reset_defaults();
        logic [31:0] rdata;
        logic        slverr;
        start_test("reset_defaults");
        read_reg(REG_LED, rdata, slverr);
        check_value("led reg", 0, rdata);
        read_reg(REG_ECHO, rdata, slverr);
        check_value("echo reg", 0, rdata);
        check_value("echo slverr", 0, slverr);
        check_status(0);
        read_reg(REG_DATA, rdata, slverr);
        check_value("empty read slverr", 1, slverr);
        check_value("led port", 0, led);
        end_test();
    endtask

    task automatic echo_led_regs();
        logic [31:0] value;
        logic [31:0] rdata;
        logic        slverr;
        start_test("echo_led_regs");
        value = lcg_next();
        write_reg(REG_ECHO, value);
        read_reg(REG_ECHO, rdata, slverr);
        check_value("echo readback", value, rdata);
        value = lcg_next();
        write_reg(REG_LED, value);
        read_reg(REG_LED, rdata, slverr);
        check_value("led readback", value & 32'hF, rdata);
        check_value("led port", value[3:0], led);
        read_reg(4'hE, rdata, slverr);  // No register there
        check_value("bad address slverr", 1, slverr);
        end_test();
    endtask

    task automatic block_capture();
        start_test("block_capture");
        send_words(BLOCK_WORDS, 1'b1);
        exp_mode = sent_words[8][11:8];
        exp_blocks++;
        check_status(BLOCK_WORDS);
        drain_and_compare();
        end_test();
    endtask

    task automatic back_pressure();
        logic [WORD_W-1:0] held_word;
        logic [31:0]       rdata;
        logic              slverr;
        start_test("back_pressure");
        send_words(FIFO_DEPTH, 1'b1);
        exp_mode = sent_words[BLOCK_WORDS + 8][11:8];  // Second block wins
        exp_blocks += 2;
        check_status(FIFO_DEPTH);
        held_word = WORD_W'(lcg_next() >> 16);
        step_past_edge();
        datin = '{trigger: 1'b1, data: held_word};
        repeat (20) begin
            @(negedge sd_datInWrite_clk);
            check_value("ready while full", 0, datin_ready);
        end
        read_reg(REG_DATA, rdata, slverr);
        check_value("first word", sent_words.pop_front(), rdata);
        wait_accept();
        sent_words.push_back(held_word);
        check_status(FIFO_DEPTH);
        drain_and_compare();
        end_test();
    endtask

    task automatic block_restart();
        start_test("block_restart");
        send_words(5, 1'b0);  // Thrown away by the restart
        step_past_edge();
        datin_rst = 1'b1;
        step_past_edge();
        datin_rst = 1'b0;
        check_status(0);
        send_words(BLOCK_WORDS, 1'b1);
        exp_mode = sent_words[8][11:8];
        exp_blocks++;
        check_status(BLOCK_WORDS);
        drain_and_compare();
        end_test();
    endtask

    initial begin
        int waited;
        datin_rst = 1'b0;
        datin     = '0;
        apb_req   = '0;
        waited    = 0;
        while (spi_rst_ !== 1'b1 && waited < TIMEOUT_CYCLES) begin
            @(posedge sd_datInWrite_clk);
            waited++;
        end
        if (spi_rst_ !== 1'b1) begin
            $display("Reset was never released");
            error_count++;
        end
        reset_defaults();
        echo_led_regs();
        block_capture();
        back_pressure();
        block_restart();
        $display("Tests run: %0d, failed checks: %0d, assertion failures: %0d",
                 test_count, error_count, dut.u_asserts.assert_errors);
        if (error_count == 0 && dut.u_asserts.assert_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic sd_datInWrite_clk,
    output logic spi_rst_
);

    localparam real HALF_PERIOD  = 4.0;  // 8 ns period
    localparam int  RESET_CYCLES = 10;

    initial begin
        sd_datInWrite_clk = 1'b0;
        forever #(HALF_PERIOD) sd_datInWrite_clk = ~sd_datInWrite_clk;
    end

    initial begin
        spi_rst_ = 1'b0;
        repeat (RESET_CYCLES) @(posedge sd_datInWrite_clk);
        #1 spi_rst_ = 1'b1;  // Release just after the edge
    end

endmodule

`default_nettype wire
